// ==== ps2_macros.svh ====
// timing counts assume a 49.152 MHz system clock
// retarget the clock by editing the counts and widths together
// each _BITS width must hold its count minus one
`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// ----------------------------------------
// timers
// ----------------------------------------
`define PS2_TIMER_60US      3000  // watchdog and clock inhibit period
`define PS2_TIMER_60US_BITS 12
`define PS2_TIMER_5US       250   // debounce period
`define PS2_TIMER_5US_BITS  8

// ----------------------------------------
// frame and special scan codes
// ----------------------------------------
`define PS2_FRAME_BITS      11    // start, 8 data, parity, stop

`define PS2_EXTEND_CODE     8'hE0
`define PS2_RELEASE_CODE    8'hF0
`define PS2_LEFT_SHIFT      8'h12
`define PS2_RIGHT_SHIFT     8'h59

`endif

// ==== ps2_pkg.sv ====
// types shared by the ps2 keyboard host blocks
// line state encodings are fixed, rx_clk_l must stay at zero
`default_nettype none

package ps2_pkg;

  localparam int byte_w = 8;  // scan code and ascii width

  // line state machine, rx_clk_l at 0 so power-up lands in a harmless state
  typedef enum logic [3:0] {
    rx_clk_l            = 4'd0,
    rx_clk_h            = 4'd1,
    tx_wait_clk_h       = 4'd2,
    tx_force_clk_l      = 4'd3,
    tx_clk_h            = 4'd4,
    tx_clk_l            = 4'd5,
    tx_wait_ack         = 4'd6,
    tx_done_recovery    = 4'd7,
    tx_no_ack           = 4'd8,
    tx_rise_mark        = 4'd9,
    tx_first_wait_clk_h = 4'd10,
    tx_first_wait_clk_l = 4'd11,
    tx_reset_timer      = 4'd12,
    rx_fall_mark        = 4'd13,
    rx_rise_mark        = 4'd14
  } line_state_e;

  typedef struct packed {
    logic              done;  // one cycle, frame complete
    logic [byte_w-1:0] code;  // data bits of the frame
  } rx_byte_t;

  typedef struct packed {
    logic              extended;   // E0 came before this code
    logic              released;   // F0 came before this code
    logic [byte_w-1:0] scan_code;
    logic [byte_w-1:0] ascii;
  } key_event_t;

endpackage

`default_nettype wire

// ==== ps2_link.sv ====
// ps2 line layer, shared by receive and transmit
// lines are only driven low, pullups on both lines are required
// system clock must run well above the ps2 clock (debounce is 5 us)
// no receive parity check
`default_nettype none
`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_link (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [7:0]            tx_data,
  input  logic                  tx_write,
  inout  wire                   ps2_clk,
  inout  wire                   ps2_data,
  output logic                  tx_write_ack,
  output logic                  tx_error_no_keyboard_ack,
  output ps2_pkg::rx_byte_t     rx_byte
);

  localparam logic [3:0] frame_bits = 4'(`PS2_FRAME_BITS);
  localparam logic [`PS2_TIMER_60US_BITS-1:0] t60_last =
    `PS2_TIMER_60US_BITS'(`PS2_TIMER_60US - 1);
  localparam logic [`PS2_TIMER_5US_BITS-1:0] t5_last =
    `PS2_TIMER_5US_BITS'(`PS2_TIMER_5US - 1);

  ps2_pkg::line_state_e state, next_state;

  logic clk_s, data_s;          // synchronized lines
  logic clk_hi_z, data_hi_z;    // released when high
  logic [3:0] bit_count;
  logic [`PS2_FRAME_BITS-1:0] q;  // shared shift register, lsb goes out first
  logic en_60us, en_5us;
  logic [`PS2_TIMER_60US_BITS-1:0] t60_count;
  logic [`PS2_TIMER_5US_BITS-1:0] t5_count;
  logic t60_done, t5_done;
  logic rx_done, tx_shift_done, shift_now;

  // open drain pads
  assign ps2_clk  = clk_hi_z  ? 1'bz : 1'b0;
  assign ps2_data = data_hi_z ? 1'bz : 1'b0;

  always_ff @(posedge clk)
  begin
    clk_s  <= ps2_clk;
    data_s <= ps2_data;
  end

  // ----------------------------------------
  // line state machine
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset) state <= ps2_pkg::rx_clk_h;
    else state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    clk_hi_z   = 1'b1;
    data_hi_z  = 1'b1;
    en_60us    = 1'b0;
    en_5us     = 1'b0;
    case (state)
      ps2_pkg::rx_clk_h:
      begin
        en_60us = 1'b1;  // doubles as receive watchdog
        if (tx_write) next_state = ps2_pkg::tx_reset_timer;
        else if (!clk_s) next_state = ps2_pkg::rx_fall_mark;
      end
      ps2_pkg::rx_fall_mark: next_state = ps2_pkg::rx_clk_l;  // bit sampled here
      ps2_pkg::rx_rise_mark: next_state = ps2_pkg::rx_clk_h;
      ps2_pkg::rx_clk_l:
      begin
        en_60us = 1'b1;
        if (tx_write) next_state = ps2_pkg::tx_reset_timer;  // aborts receive
        else if (clk_s) next_state = ps2_pkg::rx_rise_mark;
      end
      ps2_pkg::tx_reset_timer: next_state = ps2_pkg::tx_force_clk_l;
      ps2_pkg::tx_force_clk_l:
      begin
        en_60us  = 1'b1;
        clk_hi_z = 1'b0;  // inhibit the keyboard
        if (t60_done) next_state = ps2_pkg::tx_first_wait_clk_h;
      end
      ps2_pkg::tx_first_wait_clk_h:
      begin
        en_5us    = 1'b1;
        data_hi_z = 1'b0;  // start bit, request to send
        if (!clk_s && t5_done) next_state = ps2_pkg::tx_clk_l;
      end
      ps2_pkg::tx_wait_clk_h:
      begin
        en_5us    = 1'b1;
        data_hi_z = q[0];
        if (clk_s && t5_done) next_state = ps2_pkg::tx_rise_mark;
      end
      ps2_pkg::tx_rise_mark:
      begin
        data_hi_z  = q[0];
        next_state = ps2_pkg::tx_clk_h;
      end
      ps2_pkg::tx_clk_h:
      begin
        data_hi_z = q[0];
        if (tx_shift_done) next_state = ps2_pkg::tx_wait_ack;
        else if (!clk_s) next_state = ps2_pkg::tx_clk_l;
      end
      ps2_pkg::tx_clk_l:
      begin
        data_hi_z = q[0];
        if (clk_s) next_state = ps2_pkg::tx_wait_clk_h;
      end
      ps2_pkg::tx_wait_ack:
      begin
        // keyboard pulls data low with its clock to acknowledge
        if (!clk_s && data_s) next_state = ps2_pkg::tx_no_ack;
        else if (!clk_s && !data_s) next_state = ps2_pkg::tx_done_recovery;
      end
      ps2_pkg::tx_done_recovery:
        if (clk_s && data_s) next_state = ps2_pkg::rx_clk_h;
      ps2_pkg::tx_no_ack:
        if (clk_s && data_s) next_state = ps2_pkg::rx_clk_h;
      default: next_state = ps2_pkg::rx_clk_h;
    endcase
  end

  assign tx_error_no_keyboard_ack = (state == ps2_pkg::tx_no_ack);  // held until idle
  assign tx_write_ack = tx_write &&
                        ((state == ps2_pkg::rx_clk_h) || (state == ps2_pkg::rx_clk_l));

  // ----------------------------------------
  // bit counter and shift register
  // ----------------------------------------
  assign shift_now = (state == ps2_pkg::rx_fall_mark) || (state == ps2_pkg::tx_rise_mark);
  assign rx_done       = (bit_count == frame_bits);
  assign tx_shift_done = (bit_count == frame_bits - 4'd1);  // stop bit on the line

  always_ff @(posedge clk)
  begin
    if (reset || rx_done) bit_count <= '0;
    else if (state == ps2_pkg::tx_wait_ack || state == ps2_pkg::tx_reset_timer)
      bit_count <= '0;  // a receive cut short leaves a stale count
    else if (t60_done && state == ps2_pkg::rx_clk_h && clk_s)
      bit_count <= '0;  // idle line, lets a keyboard be hot plugged
    else if (shift_now)
      bit_count <= bit_count + 4'd1;
  end

  always_ff @(posedge clk)
  begin
    if (tx_write_ack) q <= {1'b1, ~^tx_data, tx_data, 1'b0};  // stop, odd parity, data, start
    else if (shift_now) q <= {data_s, q[`PS2_FRAME_BITS-1:1]};
  end

  assign rx_byte.done = rx_done;
  assign rx_byte.code = q[ps2_pkg::byte_w:1];

  // ----------------------------------------
  // timers, saturate at terminal count
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || !en_60us) t60_count <= '0;
    else if (!t60_done) t60_count <= t60_count + 1'b1;
  end
  assign t60_done = (t60_count == t60_last);

  always_ff @(posedge clk)
  begin
    if (reset || !en_5us) t5_count <= '0;
    else if (!t5_done) t5_count <= t5_count + 1'b1;
  end
  assign t5_done = (t5_count == t5_last);

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_bit_count_range: assert property (@(posedge clk) disable iff (reset)
    bit_count <= frame_bits);

endmodule

`default_nettype wire

// ==== ps2_scan_decoder.sv ====
// turns received bytes into key events
// E0 and F0 only set hold bits, the next plain code makes the event
// no queue, a new event overwrites one that was not read yet
`default_nettype none
`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_scan_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  ps2_pkg::rx_byte_t    rx_byte,
  input  logic [7:0]           ascii,
  input  logic                 rx_read,
  output logic [7:0]           code,
  output logic                 shift_on,
  output ps2_pkg::key_event_t  key_event,
  output logic                 rx_data_ready
);

  logic hold_ext, hold_rel;        // prefixes seen since the last event
  logic left_shift, right_shift;
  logic is_ext, is_rel;
  logic key_strobe;                // non-prefix byte completed

  assign code     = rx_byte.code;  // ascii map looks at the live byte
  assign shift_on = left_shift || right_shift;

  assign is_ext     = rx_byte.done && (rx_byte.code == `PS2_EXTEND_CODE);
  assign is_rel     = rx_byte.done && (rx_byte.code == `PS2_RELEASE_CODE);
  assign key_strobe = rx_byte.done && !is_ext && !is_rel;

  // ----------------------------------------
  // prefix and shift state
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || key_strobe)
    begin
      hold_ext <= 1'b0;
      hold_rel <= 1'b0;
    end
    else
    begin
      if (is_ext) hold_ext <= 1'b1;
      if (is_rel) hold_rel <= 1'b1;
    end
  end

  // make sets, break (after F0) clears
  always_ff @(posedge clk)
  begin
    if (reset) left_shift <= 1'b0;
    else if (rx_byte.done && rx_byte.code == `PS2_LEFT_SHIFT) left_shift <= !hold_rel;
  end

  always_ff @(posedge clk)
  begin
    if (reset) right_shift <= 1'b0;
    else if (rx_byte.done && rx_byte.code == `PS2_RIGHT_SHIFT) right_shift <= !hold_rel;
  end

  // ----------------------------------------
  // event register and ready flag
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset) key_event <= '0;
    else if (key_strobe)
    begin
      key_event.extended  <= hold_ext;
      key_event.released  <= hold_rel;
      key_event.scan_code <= rx_byte.code;
      key_event.ascii     <= ascii;  // uses shift state from before this byte
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset) rx_data_ready <= 1'b0;
    else if (key_strobe) rx_data_ready <= 1'b1;  // new data wins over a read
    else if (rx_read) rx_data_ready <= 1'b0;
  end

  // ready only drops after the user read it
  a_ready_held: assert property (@(posedge clk)
    $fell(rx_data_ready) |-> ($past(rx_read) || $past(reset)));

endmodule

`default_nettype wire

// ==== ps2_ascii_map.sv ====
// scan code set 2 to ascii, combinational
// only letters, digits, space, enter, backspace, tab and escape
// shifted digits and every other code give '.'
`default_nettype none
`timescale 1ns/1ps

module ps2_ascii_map (
  input  logic [7:0] code,
  input  logic       shift_on,
  output logic [7:0] ascii
);

  always_comb
  begin
    case (code)
      // control keys, shift ignored
      8'h66: ascii = 8'h08;  // backspace
      8'h0d: ascii = 8'h09;  // tab
      8'h5a: ascii = 8'h0d;  // enter
      8'h76: ascii = 8'h1b;  // escape
      8'h29: ascii = 8'h20;  // space
      // digits, no shifted symbols
      8'h45: ascii = shift_on ? 8'h2e : 8'h30;
      8'h16: ascii = shift_on ? 8'h2e : 8'h31;
      8'h1e: ascii = shift_on ? 8'h2e : 8'h32;
      8'h26: ascii = shift_on ? 8'h2e : 8'h33;
      8'h25: ascii = shift_on ? 8'h2e : 8'h34;
      8'h2e: ascii = shift_on ? 8'h2e : 8'h35;
      8'h36: ascii = shift_on ? 8'h2e : 8'h36;
      8'h3d: ascii = shift_on ? 8'h2e : 8'h37;
      8'h3e: ascii = shift_on ? 8'h2e : 8'h38;
      8'h46: ascii = shift_on ? 8'h2e : 8'h39;
      // letters, upper case with shift
      8'h1c: ascii = shift_on ? 8'h41 : 8'h61;  // a
      8'h32: ascii = shift_on ? 8'h42 : 8'h62;
      8'h21: ascii = shift_on ? 8'h43 : 8'h63;
      8'h23: ascii = shift_on ? 8'h44 : 8'h64;
      8'h24: ascii = shift_on ? 8'h45 : 8'h65;
      8'h2b: ascii = shift_on ? 8'h46 : 8'h66;
      8'h34: ascii = shift_on ? 8'h47 : 8'h67;
      8'h33: ascii = shift_on ? 8'h48 : 8'h68;
      8'h43: ascii = shift_on ? 8'h49 : 8'h69;
      8'h3b: ascii = shift_on ? 8'h4a : 8'h6a;
      8'h42: ascii = shift_on ? 8'h4b : 8'h6b;
      8'h4b: ascii = shift_on ? 8'h4c : 8'h6c;
      8'h3a: ascii = shift_on ? 8'h4d : 8'h6d;  // m
      8'h31: ascii = shift_on ? 8'h4e : 8'h6e;
      8'h44: ascii = shift_on ? 8'h4f : 8'h6f;
      8'h4d: ascii = shift_on ? 8'h50 : 8'h70;
      8'h15: ascii = shift_on ? 8'h51 : 8'h71;
      8'h2d: ascii = shift_on ? 8'h52 : 8'h72;
      8'h1b: ascii = shift_on ? 8'h53 : 8'h73;
      8'h2c: ascii = shift_on ? 8'h54 : 8'h74;
      8'h3c: ascii = shift_on ? 8'h55 : 8'h75;
      8'h2a: ascii = shift_on ? 8'h56 : 8'h76;
      8'h1d: ascii = shift_on ? 8'h57 : 8'h77;
      8'h22: ascii = shift_on ? 8'h58 : 8'h78;
      8'h35: ascii = shift_on ? 8'h59 : 8'h79;
      8'h1a: ascii = shift_on ? 8'h5a : 8'h7a;  // z
      default: ascii = 8'h2e;  // '.' for anything unlisted
    endcase
  end

endmodule

`default_nettype wire

// ==== ps2_keyboard.sv ====
// ps2 keyboard host, top level
// pullups on ps2_clk and ps2_data are required
// hold tx_write until tx_write_ack, pulse rx_read to clear rx_data_ready
`default_nettype none
`timescale 1ns/1ps

module ps2_keyboard (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           tx_data,
  input  logic                 tx_write,
  input  logic                 rx_read,
  inout  wire                  ps2_clk,
  inout  wire                  ps2_data,
  output logic                 tx_write_ack,
  output logic                 tx_error_no_keyboard_ack,
  output ps2_pkg::key_event_t  rx_key,
  output logic                 rx_shift_key_on,
  output logic                 rx_data_ready
);

  ps2_pkg::rx_byte_t rx_byte;  // completed frame from the line layer
  logic [7:0] code;
  logic [7:0] ascii;

  ps2_link i_ps2_link (
    .clk, .reset, .tx_data, .tx_write,
    .ps2_clk, .ps2_data,
    .tx_write_ack, .tx_error_no_keyboard_ack,
    .rx_byte
  );

  ps2_scan_decoder i_ps2_scan_decoder (
    .clk, .reset, .rx_byte, .ascii, .rx_read,
    .code, .shift_on(rx_shift_key_on),
    .key_event(rx_key), .rx_data_ready
  );

  ps2_ascii_map i_ps2_ascii_map (.code, .shift_on(rx_shift_key_on), .ascii);

endmodule

`default_nettype wire

// ==== tb_ps2_device.sv ====
// behavioral ps2 keyboard, simulation only
// clock half period is 300 system cycles, above the host's 5 us debounce
// lines are only pulled low or released, pullups sit in the testbench
// receive_byte expects the host to inhibit the clock first
`default_nettype none
`timescale 1ns/1ps

module tb_ps2_device (
  input  wire clk,
  inout  wire ps2_clk,
  inout  wire ps2_data
);

  localparam int half_cycles = 300;  // keyboard clock half period
  localparam int idle_cycles = 200;  // gap after a frame, well inside the 60 us watchdog

  logic clk_low;   // keyboard pulls its clock low
  logic data_low;  // keyboard pulls data low

  assign ps2_clk  = clk_low  ? 1'b0 : 1'bz;
  assign ps2_data = data_low ? 1'b0 : 1'bz;

  initial
  begin
    clk_low  = 1'b0;
    data_low = 1'b0;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // ----------------------------------------
  // keyboard to host
  // ----------------------------------------
  task automatic send_byte(input logic [7:0] code);
    logic [10:0] frame;
    int i;
    frame = {1'b1, ~^code, code, 1'b0};  // stop, odd parity, data, start
    @(negedge clk);
    for (i = 0; i < 11; i++)
    begin
      data_low = !frame[i];  // data settles while the clock is high
      wait_cycles(half_cycles);
      clk_low = 1'b1;        // host samples on this fall
      wait_cycles(half_cycles);
      clk_low = 1'b0;
    end
    data_low = 1'b0;
    wait_cycles(idle_cycles);
  endtask

  // ----------------------------------------
  // host to keyboard
  // ----------------------------------------
  task automatic receive_byte(input logic give_ack, output logic [7:0] code,
                              output logic frame_ok);
    logic [9:0] bits;  // start, 8 data, parity in line order
    logic stop_bit;
    int i;
    bits = '0;
    wait (ps2_clk == 1'b0);  // host inhibit
    wait (ps2_clk == 1'b1);  // released, data low is the request to send
    @(negedge clk);
    wait_cycles(half_cycles);
    for (i = 0; i < 10; i++)
    begin
      clk_low = 1'b1;
      wait_cycles(half_cycles);
      clk_low = 1'b0;
      bits[i] = ps2_data;  // read on the rising clock
      wait_cycles(half_cycles);
    end
    stop_bit = ps2_data;   // host has released data by now
    code     = bits[8:1];
    frame_ok = (bits[0] == 1'b0) && (^bits[9:1] == 1'b1) && (stop_bit == 1'b1);
    if (give_ack)
    begin
      data_low = 1'b1;     // ack, data low ahead of the clock
      wait_cycles(1);
    end
    clk_low = 1'b1;
    wait_cycles(half_cycles);
    clk_low  = 1'b0;
    data_low = 1'b0;
    wait_cycles(idle_cycles);
  endtask

endmodule

`default_nettype wire

// ==== tb_ps2_keyboard.sv ====
// testbench for the ps2 keyboard host
// a behavioral keyboard sends scan codes and takes host commands
// timer counts are the 49.152 MHz defaults, one frame is about 6800 cycles
`default_nettype none
`timescale 1ns/1ps

module tb_ps2_keyboard;

  // 38 frames of about 6800 cycles and two commands of about 10000, with margin
  localparam int cycle_limit = 400000;
  localparam int ready_limit = 2000;
  localparam int tx_limit    = 15000;  // inhibit plus ten keyboard clocks

  // set 2 make codes as {scan, ascii}, a to z then 0 to 9
  localparam logic [15:0] key_table [0:35] = '{
    16'h1c61, 16'h3262, 16'h2163, 16'h2364, 16'h2465, 16'h2b66, 16'h3467, 16'h3368,
    16'h4369, 16'h3b6a, 16'h426b, 16'h4b6c, 16'h3a6d, 16'h316e, 16'h446f, 16'h4d70,
    16'h1571, 16'h2d72, 16'h1b73, 16'h2c74, 16'h3c75, 16'h2a76, 16'h1d77, 16'h2278,
    16'h3579, 16'h1a7a, 16'h4530, 16'h1631, 16'h1e32, 16'h2633, 16'h2534, 16'h2e35,
    16'h3636, 16'h3d37, 16'h3e38, 16'h4639
  };

  logic clk;
  logic reset;
  logic [7:0] tx_data;
  logic tx_write;
  logic rx_read;
  wire ps2_clk;
  wire ps2_data;
  logic tx_write_ack;
  logic tx_error_no_keyboard_ack;
  ps2_pkg::key_event_t rx_key;
  logic rx_shift_key_on;
  logic rx_data_ready;
  int error_count;
  int check_count;
  int cycle_count;
  logic [31:0] rng;  // xorshift state
  logic ready_dropped;  // rx_data_ready seen low since last cleared
  logic no_ack_seen;    // tx_error_no_keyboard_ack seen high since last cleared

  pullup (ps2_clk);
  pullup (ps2_data);

  ps2_keyboard i_ps2_keyboard (
    .clk, .reset, .tx_data, .tx_write, .rx_read,
    .ps2_clk, .ps2_data,
    .tx_write_ack, .tx_error_no_keyboard_ack,
    .rx_key, .rx_shift_key_on, .rx_data_ready
  );

  tb_ps2_device kbd (.clk, .ps2_clk, .ps2_data);

  always #4 clk = ~clk;  // 8 ns

  // sticky watch on levels that must hold across a whole frame
  always @(negedge clk)
  begin
    if (!rx_data_ready) ready_dropped = 1'b1;
    if (tx_error_no_keyboard_ack) no_ack_seen = 1'b1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int random_index(input int range);
    rng = xorshift32(rng);
    return int'(rng % 32'(range));
  endfunction

  // ----------------------------------------
  // checks and handshakes
  // ----------------------------------------
  task automatic check_value(input string what, input logic [7:0] got,
                             input logic [7:0] expected);
    check_count++;
    if (got !== expected)
    begin
      error_count++;
      $display("MISMATCH at %0t ns: %s is %02h, expected %02h", $time, what, got, expected);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!rx_data_ready && n < ready_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!rx_data_ready)
    begin
      error_count++;
      $display("no key event at %0t ns, rx_data_ready stayed low", $time);
    end
  endtask

  task automatic expect_key(input logic [7:0] code, input logic [7:0] ascii,
                            input logic ext, input logic rel);
    wait_ready();
    check_value("scan_code", rx_key.scan_code, code);
    check_value("ascii", rx_key.ascii, ascii);
    check_value("extended", 8'(rx_key.extended), 8'(ext));
    check_value("released", 8'(rx_key.released), 8'(rel));
  endtask

  task automatic read_key();
    @(negedge clk);
    rx_read = 1'b1;
    @(negedge clk);
    rx_read = 1'b0;
    check_value("rx_data_ready after read", 8'(rx_data_ready), 8'h00);
  endtask

  task automatic key_round_trip(input int k);
    kbd.send_byte(key_table[k][15:8]);
    expect_key(key_table[k][15:8], key_table[k][7:0], 1'b0, 1'b0);
    read_key();
  endtask

  // hold tx_write until the ack, sampled mid low phase
  task automatic write_command(input logic [7:0] value);
    int n;
    n = 0;
    @(negedge clk);
    tx_data  = value;
    tx_write = 1'b1;
    #2;
    while (!tx_write_ack && n < 100)
    begin
      @(negedge clk);
      #2;
      n++;
    end
    if (!tx_write_ack)
    begin
      error_count++;
      $display("tx_write_ack never came at %0t ns", $time);
    end
    @(negedge clk);
    tx_write = 1'b0;
  endtask

  task automatic wait_no_ack();
    int n;
    n = 0;
    while (!tx_error_no_keyboard_ack && n < tx_limit)
    begin
      @(negedge clk);
      n++;
    end
    check_count++;
    if (!tx_error_no_keyboard_ack)
    begin
      error_count++;
      $display("tx_error_no_keyboard_ack never rose, checked at %0t ns", $time);
    end
    else if (ps2_clk && ps2_data)
    begin
      error_count++;
      $display("tx_error_no_keyboard_ack rose only after both lines were high");
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic plain_keys();
    int i;
    for (i = 0; i < 20; i++)
      key_round_trip(random_index(36));
  endtask

  task automatic prefix_keys();
    int k;
    k = random_index(36);
    kbd.send_byte(8'he0);
    check_value("rx_data_ready after E0", 8'(rx_data_ready), 8'h00);
    kbd.send_byte(key_table[k][15:8]);
    expect_key(key_table[k][15:8], key_table[k][7:0], 1'b1, 1'b0);
    read_key();
    kbd.send_byte(8'hf0);
    check_value("rx_data_ready after F0", 8'(rx_data_ready), 8'h00);
    kbd.send_byte(key_table[k][15:8]);
    expect_key(key_table[k][15:8], key_table[k][7:0], 1'b0, 1'b1);
    read_key();
    key_round_trip(random_index(36));  // both flags clear again
  endtask

  task automatic shift_one(input logic [7:0] shift_code);
    int k;
    k = random_index(26);  // letters only
    kbd.send_byte(shift_code);
    expect_key(shift_code, 8'h2e, 1'b0, 1'b0);
    check_value("rx_shift_key_on after make", 8'(rx_shift_key_on), 8'h01);
    read_key();
    kbd.send_byte(key_table[k][15:8]);
    expect_key(key_table[k][15:8], key_table[k][7:0] - 8'h20, 1'b0, 1'b0);  // upper case
    read_key();
    kbd.send_byte(8'hf0);
    kbd.send_byte(shift_code);
    expect_key(shift_code, 8'h2e, 1'b0, 1'b1);
    check_value("rx_shift_key_on after break", 8'(rx_shift_key_on), 8'h00);
    read_key();
  endtask

  task automatic shift_keys();
    shift_one(8'h12);  // left
    shift_one(8'h59);  // right
    kbd.send_byte(8'h0e);
    expect_key(8'h0e, 8'h2e, 1'b0, 1'b0);  // unmapped
    read_key();
    kbd.send_byte(8'h5a);
    expect_key(8'h5a, 8'h0d, 1'b0, 1'b0);  // enter
    read_key();
  endtask

  task automatic hold_without_read();
    int k;
    int m;
    k = random_index(36);
    m = (k + 1 + random_index(35)) % 36;  // never the same key
    kbd.send_byte(key_table[k][15:8]);
    wait_ready();
    ready_dropped = 1'b0;  // watched through the whole second frame
    kbd.send_byte(key_table[m][15:8]);
    check_value("rx_data_ready held", 8'(rx_data_ready && !ready_dropped), 8'h01);
    expect_key(key_table[m][15:8], key_table[m][7:0], 1'b0, 1'b0);
    read_key();
  endtask

  task automatic transmit_command(input logic give_ack);
    logic [7:0] value;
    logic [7:0] got;
    logic frame_ok;
    value = 8'(random_index(256));
    no_ack_seen = 1'b0;
    fork
      kbd.receive_byte(give_ack, got, frame_ok);
      begin
        write_command(value);
        if (!give_ack) wait_no_ack();
      end
    join
    check_value("byte at keyboard", got, value);
    check_count++;
    if (!frame_ok)
    begin
      error_count++;
      $display("bad start, parity or stop bit in host frame at %0t ns", $time);
    end
    check_value("tx_error_no_keyboard_ack", 8'(tx_error_no_keyboard_ack), 8'h00);
    if (give_ack)
    begin
      check_value("tx_error_no_keyboard_ack during frame", 8'(no_ack_seen), 8'h00);
      key_round_trip(random_index(36));  // receive still works
    end
  endtask

  // ----------------------------------------
  // run
  // ----------------------------------------
  initial
  begin
    clk           = 1'b0;
    reset         = 1'b1;
    tx_data       = '0;
    tx_write      = 1'b0;
    rx_read       = 1'b0;
    rng           = 32'd65;
    error_count   = 0;
    check_count   = 0;
    ready_dropped = 1'b0;
    no_ack_seen   = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (20) @(negedge clk);
    plain_keys();
    prefix_keys();
    shift_keys();
    hold_without_read();
    transmit_command(1'b1);
    transmit_command(1'b0);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, a test did not finish", cycle_limit);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
ps2_pkg.sv
ps2_link.sv
ps2_scan_decoder.sv
ps2_ascii_map.sv
ps2_keyboard.sv
tb_ps2_device.sv
tb_ps2_keyboard.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ps2 keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_ps2_keyboard \
  -f list.f \
  -o tb_ps2_keyboard_sim

status=0
./obj_dir/tb_ps2_keyboard_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "tests failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation PASSED"
